/* loop_pkg.sv */
// Frame loop data format
// Byte width, size defaults and transmit states

package loop_pkg;

	// Width of one frame byte
	localparam int data_width = 8;

	// Number of leading bytes compared against the pattern
	localparam int match_len_default = 2;

	// Frame buffer size in bytes, power of two
	localparam int fifo_depth_default = 64;

	// Transmit stage states
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_LOAD,
		TX_SEND
	} tx_state_e;

endpackage

/* cfg_pkg.sv */
// Frame loop configuration registers

package cfg_pkg;

	// Width of the register select
	localparam int cfg_addr_width = 3;

	// Register map
	typedef enum logic [cfg_addr_width-1:0] {
		REG_MATCH0,
		REG_MATCH1,
		REG_EDIT_OFS,
		REG_EDIT_VAL,
		REG_CTRL
	} cfg_reg_e;

	// REG_CTRL bit 0 enables matching

endpackage

/* frame_loop_rx.sv */
// Frame loop receive stage
// Pattern compare and single byte edit

`timescale 1ns/1ns

module frame_loop_rx
#(
	parameter C_MATCH_LEN = 2
)
(
	input logic clk,
	input logic reset,

	// Config

	input logic cfg_we,
	input cfg_pkg::cfg_reg_e cfg_addr,
	input logic [loop_pkg::data_width-1:0] cfg_wdata,

	// Input stream

	input logic [loop_pkg::data_width-1:0] in_data,
	input logic in_valid,
	input logic in_last,
	input logic in_error,

	// To buffer

	output logic [loop_pkg::data_width-1:0] rx_data,
	output logic rx_valid,
	output logic rx_last,
	output logic rx_error
);
	import loop_pkg::*;
	import cfg_pkg::*;

	localparam int idx_width = 16;
	localparam logic [idx_width-1:0] match_len = idx_width'(C_MATCH_LEN);

	// Programmed registers with at most two pattern bytes
	logic [1:0][data_width-1:0] match_pat;
	logic [data_width-1:0] edit_ofs, edit_val;
	logic match_en;

	// Copies taken on the first byte of a frame
	logic [1:0][data_width-1:0] frame_pat;
	logic [data_width-1:0] frame_ofs, frame_val;
	logic frame_en;

	logic [idx_width-1:0] byte_idx;
	logic match_ok;

	logic first;
	logic [1:0][data_width-1:0] act_pat;
	logic [data_width-1:0] act_ofs, act_val;
	logic act_en;
	logic [idx_width-1:0] ofs_ext;
	logic match_now, do_edit;

	always_ff @(posedge clk) begin
		if(reset) begin
			match_pat <= '0;
			edit_ofs <= '0;
			edit_val <= '0;
			match_en <= 1'b0;
		end else if(cfg_we) begin
			case(cfg_addr)
				REG_MATCH0: match_pat[0] <= cfg_wdata;
				REG_MATCH1: match_pat[1] <= cfg_wdata;
				REG_EDIT_OFS: edit_ofs <= cfg_wdata;
				REG_EDIT_VAL: edit_val <= cfg_wdata;
				REG_CTRL: match_en <= cfg_wdata[0];
				default: ;
			endcase
		end
	end

	// Live registers on the first byte and frame copies after it
	always_comb begin
		first = (byte_idx == '0);
		act_pat = first ? match_pat : frame_pat;
		act_ofs = first ? edit_ofs : frame_ofs;
		act_val = first ? edit_val : frame_val;
		act_en = first ? match_en : frame_en;
		ofs_ext = {{(idx_width-data_width){1'b0}}, act_ofs};
	end

	always_comb begin
		match_now = first | match_ok;
		if(byte_idx < match_len && in_data != act_pat[byte_idx[0]])
			match_now = 1'b0;

		do_edit = act_en && match_now && ofs_ext >= match_len && byte_idx == ofs_ext;
	end

	always_ff @(posedge clk) begin
		if(reset) begin
			byte_idx <= '0;
			match_ok <= 1'b0;
		end else if(in_valid) begin
			match_ok <= match_now;

			if(in_last)
				byte_idx <= '0;
			else if(byte_idx != '1)
				byte_idx <= byte_idx + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if(in_valid && first) begin
			frame_pat <= match_pat;
			frame_ofs <= edit_ofs;
			frame_val <= edit_val;
			frame_en <= match_en;
		end
	end

	always_ff @(posedge clk) begin
		if(reset)
			rx_valid <= 1'b0;
		else
			rx_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		rx_data <= do_edit ? act_val : in_data;
		rx_last <= in_last;
		rx_error <= in_last & in_error;
	end
endmodule

/* frame_loop_fifo.sv */
// Frame loop frame buffer
// Commit on last byte, rollback on error or overflow

`timescale 1ns/1ns

module frame_loop_fifo
#(
	parameter C_FIFO_DEPTH = 64
)
(
	input logic clk,
	input logic reset,

	// From receive stage

	input logic [loop_pkg::data_width-1:0] rx_data,
	input logic rx_valid,
	input logic rx_last,
	input logic rx_error,

	// To transmit stage

	output logic [loop_pkg::data_width-1:0] buf_data,
	output logic buf_last,
	output logic buf_valid,
	input logic buf_ready,

	output logic [31:0] overflow_count
);
	import loop_pkg::*;

	// Pointers carry one wrap bit so depth is a power of two
	localparam int addr_width = $clog2(C_FIFO_DEPTH);
	localparam logic [addr_width:0] depth_cnt = (addr_width+1)'(C_FIFO_DEPTH);

	// Byte plus last flag
	logic [data_width:0] mem [C_FIFO_DEPTH];

	logic [addr_width:0] wr_ptr, commit_ptr, rd_ptr;
	logic [addr_width:0] wr_next;
	logic dropped;
	logic full;
	logic mem_we;

	always_comb begin
		wr_next = wr_ptr + 1'b1;
		full = (wr_ptr - rd_ptr) == depth_cnt;
		mem_we = rx_valid & ~dropped & ~full;
	end

	always_ff @(posedge clk) begin
		if(mem_we)
			mem[wr_ptr[addr_width-1:0]] <= {rx_last, rx_data};
	end

	always_ff @(posedge clk) begin
		if(reset) begin
			wr_ptr <= '0;
			commit_ptr <= '0;
			dropped <= 1'b0;
			overflow_count <= '0;
		end else if(rx_valid) begin
			if(dropped) begin
				// Rest of a dropped frame
				if(rx_last) begin
					wr_ptr <= commit_ptr;
					dropped <= 1'b0;
				end
			end else if(full) begin
				overflow_count <= overflow_count + 1'b1;
				if(rx_last)
					wr_ptr <= commit_ptr;
				else
					dropped <= 1'b1;
			end else if(rx_last) begin
				if(rx_error) begin
					wr_ptr <= commit_ptr;
				end else begin
					wr_ptr <= wr_next;
					commit_ptr <= wr_next;
				end
			end else begin
				wr_ptr <= wr_next;
			end
		end
	end

	always_ff @(posedge clk) begin
		if(reset)
			rd_ptr <= '0;
		else if(buf_valid && buf_ready)
			rd_ptr <= rd_ptr + 1'b1;
	end

	// Only committed bytes are visible to the reader
	assign buf_valid = rd_ptr != commit_ptr;
	assign buf_data = mem[rd_ptr[addr_width-1:0]][data_width-1:0];
	assign buf_last = mem[rd_ptr[addr_width-1:0]][data_width];
endmodule

/* frame_loop_tx.sv */
// Frame loop transmit stage

`timescale 1ns/1ns

module frame_loop_tx
(
	input logic clk,
	input logic reset,

	// From buffer

	input logic [loop_pkg::data_width-1:0] buf_data,
	input logic buf_last,
	input logic buf_valid,
	output logic buf_ready,

	// Output stream

	output logic [loop_pkg::data_width-1:0] out_data,
	output logic out_last,
	output logic out_valid,
	input logic out_ready
);
	import loop_pkg::*;

	tx_state_e state;
	logic reload;

	// Next byte of the same frame goes out back to back
	assign reload = (state == TX_SEND) && out_ready && !out_last && buf_valid;

	always_comb begin
		buf_ready = 1'b0;
		if(state == TX_LOAD)
			buf_ready = buf_valid;
		else if(reload)
			buf_ready = 1'b1;
	end

	assign out_valid = (state == TX_SEND);

	always_ff @(posedge clk) begin
		if(reset) begin
			state <= TX_IDLE;
		end else begin
			case(state)
				TX_IDLE: begin
					if(buf_valid)
						state <= TX_LOAD;
				end

				TX_LOAD: begin
					if(buf_valid)
						state <= TX_SEND;
				end

				TX_SEND: begin
					if(out_ready && !reload)
						state <= TX_IDLE;
				end

				default: state <= TX_IDLE;
			endcase
		end
	end

	// Output register holds while out_ready is low
	always_ff @(posedge clk) begin
		if(buf_valid && buf_ready) begin
			out_data <= buf_data;
			out_last <= buf_last;
		end
	end
endmodule

/* frame_loop_top.sv */
// Frame loop top level

`timescale 1ns/1ns

module frame_loop_top
#(
	parameter C_MATCH_LEN = loop_pkg::match_len_default,
	parameter C_FIFO_DEPTH = loop_pkg::fifo_depth_default
)
(
	input logic clk,
	input logic reset,

	// Config

	input logic cfg_we,
	input cfg_pkg::cfg_reg_e cfg_addr,
	input logic [loop_pkg::data_width-1:0] cfg_wdata,

	// Input stream

	input logic [loop_pkg::data_width-1:0] in_data,
	input logic in_valid,
	input logic in_last,
	input logic in_error,

	// Output stream

	output logic [loop_pkg::data_width-1:0] out_data,
	output logic out_last,
	output logic out_valid,
	input logic out_ready,

	output logic [31:0] overflow_count
);
	import loop_pkg::*;

	logic [data_width-1:0] rx_data;
	logic rx_valid, rx_last, rx_error;

	logic [data_width-1:0] buf_data;
	logic buf_last, buf_valid, buf_ready;

	frame_loop_rx #(C_MATCH_LEN) U0
	(
		.clk(clk),
		.reset(reset),

		.cfg_we(cfg_we),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),

		.in_data(in_data),
		.in_valid(in_valid),
		.in_last(in_last),
		.in_error(in_error),

		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.rx_last(rx_last),
		.rx_error(rx_error)
	);

	frame_loop_fifo #(C_FIFO_DEPTH) U1
	(
		.clk(clk),
		.reset(reset),

		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.rx_last(rx_last),
		.rx_error(rx_error),

		.buf_data(buf_data),
		.buf_last(buf_last),
		.buf_valid(buf_valid),
		.buf_ready(buf_ready),

		.overflow_count(overflow_count)
	);

	frame_loop_tx U2
	(
		.clk(clk),
		.reset(reset),

		.buf_data(buf_data),
		.buf_last(buf_last),
		.buf_valid(buf_valid),
		.buf_ready(buf_ready),

		.out_data(out_data),
		.out_last(out_last),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);
endmodule

/* frame_loop_sva.sv */
// Frame loop output assertions

`timescale 1ns/1ns

module frame_loop_sva (
	input logic clk,
	input logic reset,
	input logic [loop_pkg::data_width-1:0] out_data,
	input logic out_last,
	input logic out_valid,
	input logic out_ready,
	input logic [31:0] overflow_count
);
	// Stalled output holds its byte
	assert property (@(posedge clk) disable iff(reset)
		out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
		else $error("Output changed while stalled");

	assert property (@(posedge clk) reset |=> !out_valid)
		else $error("out_valid high during reset");

	assert property (@(posedge clk) disable iff(reset)
		!$past(reset) |-> overflow_count >= $past(overflow_count))
		else $error("overflow_count decreased");
endmodule

bind frame_loop_top frame_loop_sva sva0 (
	.clk(clk),
	.reset(reset),
	.out_data(out_data),
	.out_last(out_last),
	.out_valid(out_valid),
	.out_ready(out_ready),
	.overflow_count(overflow_count)
);

/* frame_loop_tb.sv */
// Frame loop testbench

`timescale 1ns/1ns

module frame_loop_tb;
	import loop_pkg::*;
	import cfg_pkg::*;

	logic clk;
	logic reset;
	logic cfg_we;
	cfg_reg_e cfg_addr;
	logic [data_width-1:0] cfg_wdata;
	logic [data_width-1:0] in_data;
	logic in_valid, in_last, in_error;
	logic [data_width-1:0] out_data;
	logic out_last, out_valid, out_ready;
	logic [31:0] overflow_count;

	// Pattern word holds kind in [19:16], argument in [15:8] and value in [7:0]
	logic [19:0] patterns [256];
	logic [19:0] word;
	logic [8:0] exp_byte;
	logic [8:0] expect_q [$];
	int idx;
	int errors;
	int checks;
	bit done;
	bit ready_mode;

	frame_loop_top #(.C_MATCH_LEN(match_len_default), .C_FIFO_DEPTH(64)) dut0 (
		.clk(clk),
		.reset(reset),
		.cfg_we(cfg_we),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.in_data(in_data),
		.in_valid(in_valid),
		.in_last(in_last),
		.in_error(in_error),
		.out_data(out_data),
		.out_last(out_last),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.overflow_count(overflow_count)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// One clock cycle with inputs changing 5 ns after the edge
	task automatic step_cycle;
		@(posedge clk);
		#5;
		cfg_we = 1'b0;
		in_valid = 1'b0;
		in_last = 1'b0;
		in_error = 1'b0;
		if(ready_mode)
			out_ready = ($urandom % 4) != 0;
		else
			out_ready = 1'b0;
	endtask

	task automatic cfg_write(input cfg_reg_e addr, input logic [data_width-1:0] data);
		step_cycle();
		cfg_we = 1'b1;
		cfg_addr = addr;
		cfg_wdata = data;
	endtask

	task automatic send_byte(input logic [data_width-1:0] data, input logic last,
			input logic err);
		step_cycle();
		in_valid = 1'b1;
		in_data = data;
		in_last = last;
		in_error = err;
	endtask

	// Frame of incrementing bytes
	task automatic send_ramp(input logic [7:0] len, input logic [data_width-1:0] first);
		for(int i = 0; i < len; i++)
			send_byte(first + 8'(i), i == len - 1, 1'b0);
	endtask

	task automatic expect_ramp(input logic [7:0] len, input logic [data_width-1:0] first);
		for(int i = 0; i < len; i++)
			expect_q.push_back({i == len - 1, first + 8'(i)});
	endtask

	task automatic wait_drain;
		int count;
		count = 0;
		while(expect_q.size() != 0 && count < 2000) begin
			step_cycle();
			count++;
		end
		if(expect_q.size() != 0) begin
			$display("Timeout with %0d expected output bytes still missing", expect_q.size());
			errors++;
		end
	endtask

	task automatic check_overflow(input logic [7:0] expected);
		wait_drain();
		checks++;
		if(overflow_count != 32'(expected)) begin
			$display("Fail at %0t: overflow_count is %0d, expected %0d",
				$time, overflow_count, expected);
			errors++;
		end
	endtask

	// One expected byte checked per output transfer
	always @(posedge clk) begin
		if(!reset && out_valid && out_ready) begin
			if(expect_q.size() == 0) begin
				$display("Output byte %02h arrived when no byte was expected", out_data);
				errors++;
			end else begin
				exp_byte = expect_q.pop_front();
				checks++;
				if({out_last, out_data} != exp_byte) begin
					$display("Fail at %0t: out_data %02h last %0b, expected %02h last %0b",
						$time, out_data, out_last, exp_byte[7:0], exp_byte[8]);
					errors++;
				end
			end
		end
	end

	initial begin
		void'($urandom(32'h31ce_eefd));
		reset = 1'b1;
		cfg_we = 1'b0;
		cfg_addr = REG_MATCH0;
		cfg_wdata = '0;
		in_data = '0;
		in_valid = 1'b0;
		in_last = 1'b0;
		in_error = 1'b0;
		out_ready = 1'b0;
		ready_mode = 1'b0;
		errors = 0;
		checks = 0;
		$readmemh("frame_patterns.txt", patterns);

		repeat(8) step_cycle();
		reset = 1'b0;

		idx = 0;
		done = 1'b0;
		while(!done && idx < 256) begin
			word = patterns[idx];
			idx++;
			case(word[19:16])
				4'h0: done = 1'b1;
				4'h1: cfg_write(cfg_reg_e'(word[10:8]), word[7:0]);
				4'h2: send_byte(word[7:0], word[8], word[9]);
				4'h3: expect_q.push_back({word[8], word[7:0]});
				4'h4: check_overflow(word[7:0]);
				4'h5: repeat(word[7:0]) step_cycle();
				4'h6: ready_mode = word[0];
				4'h7: send_ramp(word[15:8], word[7:0]);
				4'h8: expect_ramp(word[15:8], word[7:0]);
				4'h9: wait_drain();
				default: begin
					$display("Unknown pattern word %05h at entry %0d", word, idx - 1);
					errors++;
					done = 1'b1;
				end
			endcase
		end
		if(!done) begin
			$display("Pattern list ended without an end marker");
			errors++;
		end

		step_cycle();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if(errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end
endmodule

/* frame_patterns.txt */
// Hex words: kind [19:16], argument [15:8], value [7:0]
// 1 cfg (arg reg), 2 in byte (arg b0 last, b1 error), 3 expected byte (arg b0 last)
// 4 overflow count, 5 idle, 6 ready mode, 7/8 input/expected ramp (arg len), 9 drain, 0 end
60001
80510
70510
30055
30166
20055
20166
10010
10111
10203
103ee
80610
70610
10401
30010
30011
30012
300ee
30014
30115
70610
30010
30022
30012
30113
20010
20022
20012
20113
80310
70310
10201
80610
70610
80430
70430
20077
20078
20379
80440
70440
90000
60000
80450
70450
74660
60001
80570
70570
40001
50014
00000

/* compile.f */
loop_pkg.sv
cfg_pkg.sv
frame_loop_rx.sv
frame_loop_fifo.sv
frame_loop_tx.sv
frame_loop_top.sv
frame_loop_sva.sv
frame_loop_tb.sv

/* Makefile */
TOP = frame_loop_tb

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f compile.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log || exit 1

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
